//--- dv/spi_flash_trace.txt
# opcode addr has_addr rd_bytes flash_data mosi_word mosi_bits rd_data
# hex fields, has_addr rd_bytes mosi_bits decimal, flash_data is the byte stream MSB first
06 000000 0 0 5a5a5a5a 00000006  8 00000000
04 000000 0 0 12345678 00000004  8 00000000
05 000000 0 1 02a5c3e1 00000500 16 00000002
9f 000000 0 3 ef4018aa 9f000000 32 00ef4018
03 001000 1 4 deadbeef 03001000 64 deadbeef
03 123456 1 1 a1b2c3d4 03123456 40 000000a1
03 abcdef 1 2 13579bdf 03abcdef 48 00001357
0b ffffff 1 3 2468ace0 0bffffff 56 002468ac
20 010000 1 0 ffffffff 20010000 32 00000000
d8 7f0000 1 0 a5a5a5a5 d87f0000 32 00000000
05 000000 0 2 8001c3a5 00050000 24 00008001
35 000000 0 1 7e000000 00003500 16 0000007e
03 000000 1 4 ffffffff 03000000 64 ffffffff
03 fedcba 1 4 00000001 03fedcba 64 00000001
9f 000000 0 4 c2201901 9f000000 40 c2201901
b9 555555 0 0 ffffffff 000000b9  8 00000000
ab aaaaaa 0 1 15000000 0000ab00 16 00000015
0b 800001 1 1 3c3c3c3c 0b800001 40 0000003c
03 5a5a5a 1 3 0f1e2d3c 035a5a5a 56 000f1e2d
66 000000 0 0 00000000 00000066  8 00000000
99 000000 0 0 ffffffff 00000099  8 00000000
03 00ff00 1 2 00ff00ff 0300ff00 48 000000ff

//--- tb.f
source/spi_flash_pkg.sv
source/sclk_gen.sv
source/spi_shifter.sv
source/spi_op_sequencer.sv
source/spi_flash_master.sv
dv/spi_flash_master_tb.sv

//--- Bender.yml
package:
  name: spi_flash_master

sources:
  - source/spi_flash_pkg.sv
  - source/sclk_gen.sv
  - source/spi_shifter.sv
  - source/spi_op_sequencer.sv
  - source/spi_flash_master.sv
  - target: test
    files:
      - dv/spi_flash_master_tb.sv

//--- dv/spi_flash_master_tb.sv
`timescale 1ns/10ps

module spi_flash_master_tb
    import spi_flash_pkg::*;
();

    localparam int MAX_CMDS = 64;
    localparam int MAX_GAP = 4;
    localparam logic SCLK_IDLE = (CPOL != 0);
    // longest command is opcode, address and four read bytes
    localparam int WORST_CMD_CLKS = 1 + CS_SETUP_CLKS + 1 + CS_HOLD_CLKS + 1
        + 2 * (OPCODE_W + ADDR_W + RX_W) * CLKS_PER_HALF_SCLK;

    logic     clk;
    logic     rst;
    logic     cmd_valid;
    spi_cmd_t cmd;
    logic     busy;
    logic     rsp_valid;
    spi_rsp_t rsp;
    logic     cs_n;
    logic     sclk;
    logic     mosi;
    logic     miso;

    spi_cmd_t        trace_cmd [MAX_CMDS];
    logic [31:0]     trace_flash [MAX_CMDS];
    logic [TX_W-1:0] trace_mosi [MAX_CMDS];
    int              trace_bits [MAX_CMDS];
    logic [RX_W-1:0] trace_rd [MAX_CMDS];
    int              n_cmds = 0;
    bit              trace_ready = 1'b0;

    int mismatch_cnt = 0;
    int fail_cnt = 0;
    int rsp_cnt = 0;

    logic [31:0]     cur_flash;
    int              cur_cmd_bits;
    logic [31:0]     flash_shift;
    int              fall_cnt;
    logic [TX_W-1:0] mosi_word;
    int              mosi_cnt;

    spi_flash_master spi_flash_master_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .cs_n      (cs_n),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the flash model answers only after the opcode and address have gone by
    always @(negedge cs_n) begin
        fall_cnt = 0;
        mosi_cnt = 0;
        mosi_word = '0;
        flash_shift = cur_flash;
        miso <= 1'b1; // line rests high through the pull-up
    end

    always @(posedge sclk) begin
        if (!rst && !cs_n) begin
            if (mosi_cnt < TX_W) begin
                mosi_word = {mosi_word[TX_W-2:0], mosi};
            end
            mosi_cnt = mosi_cnt + 1;
        end
    end

    always @(negedge sclk) begin
        if (!rst && cs_n) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: sclk fell while cs_n was high", $time);
        end else if (!rst) begin
            fall_cnt = fall_cnt + 1;
            if (fall_cnt > cur_cmd_bits) begin
                miso <= flash_shift[31];
                flash_shift = flash_shift << 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && rsp_valid) begin
            rsp_cnt++;
        end
    end

    task automatic check_rsp(input spi_rsp_t got, input spi_rsp_t exp, input int idx);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: command %0d rsp %h/%0d, expected %h/%0d", $time, idx,
                got.rd_data, got.rd_bytes, exp.rd_data, exp.rd_bytes);
        end
    endtask

    task automatic check_mosi(input logic [TX_W-1:0] got_word, input int got_bits,
                              input logic [TX_W-1:0] exp_word, input int exp_bits,
                              input int idx);
        if (got_word !== exp_word || got_bits != exp_bits) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: command %0d mosi %h in %0d bits, expected %h in %0d",
                $time, idx, got_word, got_bits, exp_word, exp_bits);
        end
    endtask

    task automatic check_idle(input string where, input bit with_status);
        if (cs_n !== 1'b1 || sclk !== SCLK_IDLE || mosi !== 1'b0) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s pins cs_n %b sclk %b mosi %b", $time, where,
                cs_n, sclk, mosi);
        end
        if (with_status && (busy !== 1'b0 || rsp_valid !== 1'b0)) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s busy %b rsp_valid %b", $time, where, busy, rsp_valid);
        end
    endtask

    initial begin : watchdog
        seq_state_t st;
        int         limit;
        wait (trace_ready);
        limit = 60 + (n_cmds + 1) * (WORST_CMD_CLKS + MAX_GAP + 4);
        repeat (limit) @(posedge clk);
        st = spi_flash_master_inst.spi_op_sequencer_inst.state;
        $display("timeout after %0d clocks, sequencer still in %s", limit, st.name());
        $display("Test failures found");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_flash;
        logic [31:0] f_mosi;
        logic [31:0] f_rd;
        int          f_has;
        int          f_rd_bytes;
        int          f_bits;
        int          gap;
        spi_cmd_t    c;
        spi_rsp_t    exp;

        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        miso = 1'b1;
        cur_flash = '0;
        cur_cmd_bits = OPCODE_W;
        void'($urandom(59218));

        fd = $fopen("dv/spi_flash_trace.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("could not open the trace file dv/spi_flash_trace.txt");
        end else begin
            while (!$feof(fd) && n_cmds < MAX_CMDS) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %d %d %h %h %d %h", f_op, f_addr, f_has,
                        f_rd_bytes, f_flash, f_mosi, f_bits, f_rd);
                    if (n == 8) begin
                        c.opcode = f_op[OPCODE_W-1:0];
                        c.addr = f_addr[ADDR_W-1:0];
                        c.has_addr = (f_has != 0);
                        c.rd_bytes = RD_BYTES_W'(f_rd_bytes);
                        trace_cmd[n_cmds] = c;
                        trace_flash[n_cmds] = f_flash;
                        trace_mosi[n_cmds] = f_mosi;
                        trace_bits[n_cmds] = f_bits;
                        trace_rd[n_cmds] = f_rd;
                        n_cmds++;
                    end
                end
            end
            $fclose(fd);
            if (n_cmds == 0) begin
                fail_cnt++;
                $display("the trace file holds no commands");
            end
        end
        trace_ready = 1'b1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_idle("after reset", 1'b1);

        for (int i = 0; i < n_cmds; i++) begin
            gap = $urandom % MAX_GAP;
            repeat (gap) @(posedge clk);
            c = trace_cmd[i];
            cur_flash = trace_flash[i];
            cur_cmd_bits = OPCODE_W + (c.has_addr ? ADDR_W : 0);
            cmd_valid <= 1'b1;
            cmd <= c;
            @(posedge clk);
            cmd_valid <= 1'b0;
            repeat (2) @(posedge clk);
            if (busy !== 1'b1) begin
                fail_cnt++;
                $display("busy was low while command %0d was running", i);
            end
            // a second request in the middle of a command must be dropped
            cmd_valid <= 1'b1;
            cmd <= ~c;
            @(posedge clk);
            cmd_valid <= 1'b0;
            @(posedge clk);
            while (!rsp_valid) @(posedge clk);
            exp.rd_data = trace_rd[i];
            exp.rd_bytes = c.rd_bytes;
            check_rsp(rsp, exp, i);
            check_mosi(mosi_word, mosi_cnt, trace_mosi[i], trace_bits[i], i);
            check_idle("after response", 1'b0);
        end

        // long enough for a wrongly accepted extra command to answer
        repeat (WORST_CMD_CLKS) @(posedge clk);
        if (rsp_cnt != n_cmds) begin
            fail_cnt++;
            $display("%0d responses came back for %0d commands", rsp_cnt, n_cmds);
        end

        $display("%0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- source/spi_flash_master.sv
`timescale 1ns/10ps

module spi_flash_master
    import spi_flash_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    input  spi_cmd_t cmd,
    output logic     busy,
    output logic     rsp_valid,
    output spi_rsp_t rsp,
    output logic     cs_n,
    output logic     sclk,
    output logic     mosi,
    input  logic     miso
);

    logic                  op_start;
    logic                  op_done;
    logic [EDGE_CNT_W-1:0] sclk_edges;
    logic                  load;
    logic [TX_W-1:0]       tx_word;
    logic [RX_W-1:0]       rx_word;
    logic                  sclk_leadedge;
    logic                  sclk_trailedge;

    spi_op_sequencer spi_op_sequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .op_done    (op_done),
        .rx_word    (rx_word),
        .busy       (busy),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .cs_n       (cs_n),
        .op_start   (op_start),
        .sclk_edges (sclk_edges),
        .load       (load),
        .tx_word    (tx_word)
    );

    sclk_gen sclk_gen_inst (
        .clk            (clk),
        .rst            (rst),
        .sclk_edges     (sclk_edges),
        .op_start       (op_start),
        .op_done        (op_done),
        .sclk_leadedge  (sclk_leadedge),
        .sclk_trailedge (sclk_trailedge),
        .sclk           (sclk)
    );

    spi_shifter spi_shifter_inst (
        .clk            (clk),
        .rst            (rst),
        .load           (load),
        .tx_word        (tx_word),
        .op_start       (op_start),
        .sclk_leadedge  (sclk_leadedge),
        .sclk_trailedge (sclk_trailedge),
        .miso           (miso),
        .mosi           (mosi),
        .rx_word        (rx_word)
    );

endmodule

//--- source/spi_op_sequencer.sv
`timescale 1ns/10ps

module spi_op_sequencer
    import spi_flash_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  spi_cmd_t              cmd,
    input  logic                  op_done,
    input  logic [RX_W-1:0]       rx_word,
    output logic                  busy,
    output logic                  rsp_valid,
    output spi_rsp_t              rsp,
    output logic                  cs_n,
    output logic                  op_start,
    output logic [EDGE_CNT_W-1:0] sclk_edges,
    output logic                  load,
    output logic [TX_W-1:0]       tx_word
);

    seq_state_t          state;
    logic [CS_CNT_W-1:0] cs_cnt;
    logic [RD_BYTES_W-1:0] rd_bytes_q;
    spi_cmd_t            cmd_norm;
    logic                accept;
    logic                hold_done;
    logic [RX_W-1:0]     rd_mask;

    function automatic spi_cmd_t clamp_cmd(spi_cmd_t c);
        spi_cmd_t r;
        r = c;
        if (c.rd_bytes > RD_BYTES_W'(MAX_RD_BYTES)) begin
            r.rd_bytes = RD_BYTES_W'(MAX_RD_BYTES);
        end
        return r;
    endfunction

    // two sclk edges per bit
    function automatic logic [EDGE_CNT_W-1:0] edge_count(spi_cmd_t c);
        logic [EDGE_CNT_W-1:0] bits;
        bits = EDGE_CNT_W'(OPCODE_W);
        if (c.has_addr) begin
            bits = bits + EDGE_CNT_W'(ADDR_W);
        end
        bits = bits + EDGE_CNT_W'({c.rd_bytes, 3'b000});
        return bits << 1;
    endfunction

    assign cmd_norm = clamp_cmd(cmd);

    // busy covers the response cycle too, a new command can follow right after it
    assign busy = (state != IDLE) || rsp_valid;
    assign accept = cmd_valid && !busy;
    assign load = (state == CS_SETUP) && (cs_cnt == '0); // the cycle before op_start rises
    assign hold_done = (state == CS_HOLD) && (cs_cnt == '0);

    // shifting all ones left by 32 leaves nothing, which gives the full mask for four bytes
    assign rd_mask = ~({RX_W{1'b1}} << {rd_bytes_q, 3'b000});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cs_cnt <= '0;
            cs_n <= 1'b1;
            op_start <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= CS_SETUP;
                        cs_n <= 1'b0;
                        cs_cnt <= CS_CNT_W'(CS_SETUP_CLKS - 1);
                    end
                end
                CS_SETUP: begin
                    if (cs_cnt == '0) begin
                        state <= XFER;
                        op_start <= 1'b1;
                    end else begin
                        cs_cnt <= cs_cnt - 1'b1;
                    end
                end
                XFER: begin
                    if (op_done) begin // dropping op_start rearms sclk_gen
                        state <= CS_HOLD;
                        op_start <= 1'b0;
                        cs_cnt <= CS_CNT_W'(CS_HOLD_CLKS - 1);
                    end
                end
                CS_HOLD: begin
                    if (cs_cnt == '0) begin
                        state <= IDLE;
                        cs_n <= 1'b1;
                        rsp_valid <= 1'b1;
                    end else begin
                        cs_cnt <= cs_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_bytes_q <= cmd_norm.rd_bytes;
            sclk_edges <= edge_count(cmd_norm);
            // opcode goes out first, an opcode-only command leaves the address bits zero
            tx_word <= {cmd_norm.opcode, cmd_norm.has_addr ? cmd_norm.addr : {ADDR_W{1'b0}}};
        end
        if (hold_done) begin
            rsp.rd_data <= rx_word & rd_mask;
            rsp.rd_bytes <= rd_bytes_q;
        end
    end

endmodule

//--- source/spi_shifter.sv
`timescale 1ns/10ps

module spi_shifter
    import spi_flash_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic [TX_W-1:0] tx_word,
    input  logic            op_start,
    input  logic            sclk_leadedge,
    input  logic            sclk_trailedge,
    input  logic            miso,
    output logic            mosi,
    output logic [RX_W-1:0] rx_word
);

    logic [TX_W-1:0] tx_reg;
    logic            launch_edge;
    logic            sample_edge;

    // CPHA 1 launches on the leading edge and samples on the trailing one
    assign launch_edge = (CPHA != 0) ? sclk_leadedge : sclk_trailedge;
    assign sample_edge = (CPHA != 0) ? sclk_trailedge : sclk_leadedge;

    // zeros shift in behind the command, so mosi stays low once it is sent
    always_ff @(posedge clk) begin
        if (load) begin
            tx_reg <= tx_word;
        end else if (op_start && launch_edge) begin
            tx_reg <= {tx_reg[TX_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mosi <= 1'b0;
        end else if (!op_start) begin
            mosi <= 1'b0;
        end else if (launch_edge) begin
            mosi <= tx_reg[TX_W-1];
        end
    end

    // every bit goes in, the read bytes are simply the last ones to arrive
    always_ff @(posedge clk) begin
        if (load) begin
            rx_word <= '0;
        end else if (op_start && sample_edge) begin
            rx_word <= {rx_word[RX_W-2:0], miso};
        end
    end

endmodule

//--- source/sclk_gen.sv
`timescale 1ns/10ps

module sclk_gen
    import spi_flash_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [EDGE_CNT_W-1:0] sclk_edges,
    input  logic                  op_start,
    output logic                  op_done,
    output logic                  sclk_leadedge,
    output logic                  sclk_trailedge,
    output logic                  sclk
);

    localparam logic SCLK_IDLE = (CPOL != 0);

    logic [HALF_CNT_W-1:0] clk_cnt;
    logic [EDGE_CNT_W-1:0] edges_left;
    logic                  lead_pt;
    logic                  trail_pt;
    logic                  running;

    // the leading edge falls in the middle of each bit period, the trailing edge at its end
    assign lead_pt = (clk_cnt == HALF_CNT_W'(CLKS_PER_HALF_SCLK - 1));
    assign trail_pt = (clk_cnt == HALF_CNT_W'(2 * CLKS_PER_HALF_SCLK - 1));
    assign running = op_start && (edges_left != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_cnt <= '0;
        end else if (!running) begin
            clk_cnt <= '0;
        end else if (trail_pt) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            edges_left <= '0;
            sclk <= SCLK_IDLE;
            sclk_leadedge <= 1'b0;
            sclk_trailedge <= 1'b0;
            op_done <= 1'b0;
        end else if (!op_start) begin
            // idle between transfers, so pick up the next edge count here
            edges_left <= sclk_edges;
            sclk <= SCLK_IDLE;
            sclk_leadedge <= 1'b0;
            sclk_trailedge <= 1'b0;
            op_done <= 1'b0;
        end else if (edges_left == '0) begin
            sclk_leadedge <= 1'b0;
            sclk_trailedge <= 1'b0;
            op_done <= 1'b1; // held until op_start drops
        end else begin
            sclk_leadedge <= lead_pt;
            sclk_trailedge <= trail_pt;
            if (lead_pt || trail_pt) begin
                sclk <= ~sclk;
                edges_left <= edges_left - 1'b1;
            end
        end
    end

endmodule

//--- source/spi_flash_pkg.sv
package spi_flash_pkg;

    // sclk timing is counted in system clocks
    localparam int CLKS_PER_HALF_SCLK = 2;
    localparam int HALF_CNT_W = $clog2(2 * CLKS_PER_HALF_SCLK);

    // mode 3 idles sclk high and launches data on the leading edge
    localparam int CPOL = 1;
    localparam int CPHA = 1;

    // cs_n stays low this many clocks around the transfer
    localparam int CS_SETUP_CLKS = 4;
    localparam int CS_HOLD_CLKS = 4;
    localparam int CS_CNT_W = $clog2(CS_SETUP_CLKS + CS_HOLD_CLKS);

    localparam int EDGE_CNT_W = 9; // 64 bits worst case need 128 edges

    localparam int OPCODE_W = 8;
    localparam int ADDR_W = 24;
    localparam int RD_BYTES_W = 3;
    localparam int MAX_RD_BYTES = 4;

    localparam int TX_W = OPCODE_W + ADDR_W;
    localparam int RX_W = 8 * MAX_RD_BYTES;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [ADDR_W-1:0]     addr;
        logic                  has_addr;
        logic [RD_BYTES_W-1:0] rd_bytes; // 0 to MAX_RD_BYTES
    } spi_cmd_t;

    // first byte read from the flash ends up as the most significant valid byte
    typedef struct packed {
        logic [RX_W-1:0]       rd_data;
        logic [RD_BYTES_W-1:0] rd_bytes;
    } spi_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        CS_SETUP,
        XFER,
        CS_HOLD
    } seq_state_t;

endpackage
